//--- rtl/spi_flash_config.svh
`ifndef SPI_FLASH_CONFIG_SVH
`define SPI_FLASH_CONFIG_SVH

// Flash address width in bits
`define SPI_ADDR_W 24

// System clocks per SCLK half period
`define SPI_HALF_SCLK 2

// Request queue entries
`define SPI_FIFO_DEPTH 4

// Opcode used for cache word reads
`define SPI_CACHE_RD_OP 8'h03

`endif

//--- rtl/spi_flash_pkg.sv
`include "spi_flash_config.svh"

package spi_flash_pkg;

   typedef logic [`SPI_ADDR_W-1:0] spi_addr_t;
   typedef logic [7:0]             spi_op_t;
   typedef logic [31:0]            spi_word_t;

   // Data bytes minus one
   typedef logic [1:0]             spi_nbytes_t;

   typedef enum logic {
      SRC_CSR   = 1'b0,
      SRC_CACHE = 1'b1
   } spi_src_e;

   typedef struct packed {
      spi_op_t     op;
      spi_addr_t   addr;
      spi_nbytes_t nbytes;
      spi_src_e    src;
   } spi_req_t;

   typedef struct packed {
      spi_word_t data;
      spi_src_e  src;
   } spi_rsp_t;

   typedef enum logic {
      ARB_IDLE,
      ARB_WAIT
   } arb_state_e;

   typedef enum logic [2:0] {
      ENG_IDLE,
      ENG_CMD,
      ENG_ADDR,
      ENG_DATA,
      ENG_DONE
   } eng_state_e;

endpackage

//--- rtl/spi_req_arbiter.sv
`timescale 1ns/1ps
`include "spi_flash_config.svh"

module spi_req_arbiter (
   input  logic                     clk_i,
   input  logic                     arst_i,
   input  logic                     flush_i,
   input  logic                     csr_valid_i,
   input  spi_flash_pkg::spi_req_t  csr_req_i,
   output logic                     csr_busy_o,
   output logic                     csr_rsp_valid_o,
   output spi_flash_pkg::spi_word_t csr_rdata_o,
   input  logic                     cache_valid_i,
   input  spi_flash_pkg::spi_addr_t cache_addr_i,
   input  logic [3:0]               cache_wstrb_i,
   output logic                     cache_ready_o,
   output spi_flash_pkg::spi_word_t cache_rdata_o,
   output logic                     push_o,
   output spi_flash_pkg::spi_req_t  push_req_o,
   input  logic                     full_i,
   input  logic                     rsp_valid_i,
   input  spi_flash_pkg::spi_rsp_t  rsp_i
);
   import spi_flash_pkg::*;

   arb_state_e state_q;
   logic       csr_pend_q;
   logic       wr_ack_q;
   logic       cache_rd;
   logic       cache_wr;
   logic       cache_push;
   logic       csr_push;
   logic       cache_rsp;
   logic       csr_rsp;

   assign cache_rd = cache_valid_i & ~(|cache_wstrb_i);
   assign cache_wr = cache_valid_i & (|cache_wstrb_i);

   // Cache reads take the queue slot before register strobes
   assign cache_push = cache_rd & (state_q == ARB_IDLE) & ~full_i & ~flush_i;
   assign csr_busy_o = full_i | csr_pend_q | cache_push | flush_i;
   assign csr_push   = csr_valid_i & ~csr_busy_o;
   assign push_o     = cache_push | csr_push;

   always_comb begin
      push_req_o     = csr_req_i;
      push_req_o.src = SRC_CSR;
      if (cache_push) begin
         push_req_o.op     = `SPI_CACHE_RD_OP;
         push_req_o.addr   = cache_addr_i;
         push_req_o.nbytes = spi_nbytes_t'(3);
         push_req_o.src    = SRC_CACHE;
      end
   end

   // Response steering by tag
   assign cache_rsp = rsp_valid_i & (rsp_i.src == SRC_CACHE) & (state_q == ARB_WAIT);
   assign csr_rsp   = rsp_valid_i & (rsp_i.src == SRC_CSR);

   assign csr_rsp_valid_o = csr_rsp;
   assign csr_rdata_o     = rsp_i.data;
   assign cache_ready_o   = cache_rsp | wr_ack_q;
   assign cache_rdata_o   = rsp_i.data;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q    <= ARB_IDLE;
         csr_pend_q <= 1'b0;
         wr_ack_q   <= 1'b0;
      end else if (flush_i) begin
         state_q    <= ARB_IDLE;
         csr_pend_q <= 1'b0;
         wr_ack_q   <= 1'b0;
      end else begin
         // Writes are acknowledged and dropped
         wr_ack_q <= cache_wr & ~wr_ack_q;
         if (csr_push) begin
            csr_pend_q <= 1'b1;
         end else if (csr_rsp) begin
            csr_pend_q <= 1'b0;
         end
         case (state_q)
            ARB_IDLE: begin
               if (cache_push) begin
                  state_q <= ARB_WAIT;
               end
            end
            ARB_WAIT: begin
               if (cache_rsp) begin
                  state_q <= ARB_IDLE;
               end
            end
            default: state_q <= ARB_IDLE;
         endcase
      end
   end

endmodule

//--- rtl/spi_req_fifo.sv
`timescale 1ns/1ps
`include "spi_flash_config.svh"

module spi_req_fifo (
   input  logic                    clk_i,
   input  logic                    arst_i,
   input  logic                    push_i,
   input  spi_flash_pkg::spi_req_t push_req_i,
   input  logic                    pop_i,
   output spi_flash_pkg::spi_req_t head_o,
   output logic                    empty_o,
   output logic                    full_o
);
   import spi_flash_pkg::*;

   localparam int DEPTH = `SPI_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   spi_req_t         mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + PTR_W'(1);
   endfunction

   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   // Flags come from the registered count
   assign empty_o = (count_q == '0);
   assign full_o  = (count_q == CNT_W'(DEPTH));
   assign head_o  = mem_q[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem_q[wr_ptr_q] <= push_req_i;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= ptr_next(wr_ptr_q);
         end
         if (do_pop) begin
            rd_ptr_q <= ptr_next(rd_ptr_q);
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + CNT_W'(1);
            2'b01:   count_q <= count_q - CNT_W'(1);
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

//--- rtl/spi_frame_engine.sv
`timescale 1ns/1ps
`include "spi_flash_config.svh"

module spi_frame_engine (
   input  logic                    clk_i,
   input  logic                    arst_i,
   input  logic                    empty_i,
   input  spi_flash_pkg::spi_req_t head_i,
   output logic                    pop_o,
   output logic                    rsp_valid_o,
   output spi_flash_pkg::spi_rsp_t rsp_o,
   output logic                    sclk_o,
   output logic                    ss_o,
   output logic                    mosi_o,
   input  logic                    miso_i
);
   import spi_flash_pkg::*;

   localparam int HALF  = `SPI_HALF_SCLK;
   localparam int DIV_W = $clog2(HALF + 1);
   localparam int TX_W  = 8 + `SPI_ADDR_W;
   localparam int BIT_W = $clog2((`SPI_ADDR_W > 32) ? `SPI_ADDR_W : 32);

   eng_state_e       state_q;
   logic [DIV_W-1:0] div_q;
   logic [BIT_W-1:0] bit_cnt_q;
   logic [TX_W-1:0]  tx_q;
   logic             sclk_q;
   logic             ss_q;
   logic             rsp_valid_q;
   spi_nbytes_t      nbytes_q;
   spi_src_e         src_q;
   logic [7:0]       byte_sr_q;
   spi_word_t        data_q;
   logic             half_end;
   logic             bit_last;
   logic [1:0]       byte_idx;

   assign pop_o    = (state_q == ENG_IDLE) & ~empty_i;
   assign half_end = (div_q == DIV_W'(HALF - 1));
   assign byte_idx = bit_cnt_q[4:3];

   // Last bit of the current phase
   always_comb begin
      case (state_q)
         ENG_CMD:  bit_last = (bit_cnt_q == BIT_W'(7));
         ENG_ADDR: bit_last = (bit_cnt_q == BIT_W'(`SPI_ADDR_W - 1));
         default:  bit_last = (bit_cnt_q == BIT_W'({nbytes_q, 3'b111}));
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q     <= ENG_IDLE;
         div_q       <= '0;
         bit_cnt_q   <= '0;
         tx_q        <= '0;
         sclk_q      <= 1'b0;
         ss_q        <= 1'b1;
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= 1'b0;
         case (state_q)
            ENG_IDLE: begin
               if (pop_o) begin
                  state_q   <= ENG_CMD;
                  ss_q      <= 1'b0;
                  div_q     <= '0;
                  bit_cnt_q <= '0;
                  tx_q      <= {head_i.op, head_i.addr};
               end
            end
            ENG_CMD, ENG_ADDR, ENG_DATA: begin
               if (half_end) begin
                  div_q  <= '0;
                  sclk_q <= ~sclk_q;
                  // Falling SCLK ends a bit and moves mosi on
                  if (sclk_q) begin
                     tx_q <= {tx_q[TX_W-2:0], 1'b0};
                     if (bit_last) begin
                        bit_cnt_q <= '0;
                        case (state_q)
                           ENG_CMD:  state_q <= ENG_ADDR;
                           ENG_ADDR: state_q <= ENG_DATA;
                           default: begin
                              state_q <= ENG_DONE;
                              ss_q    <= 1'b1;
                           end
                        endcase
                     end else begin
                        bit_cnt_q <= bit_cnt_q + BIT_W'(1);
                     end
                  end
               end else begin
                  div_q <= div_q + DIV_W'(1);
               end
            end
            ENG_DONE: begin
               state_q     <= ENG_IDLE;
               rsp_valid_q <= 1'b1;
            end
            default: begin
               state_q <= ENG_IDLE;
               ss_q    <= 1'b1;
               sclk_q  <= 1'b0;
            end
         endcase
      end
   end

   // Read data capture, bytes packed little-endian
   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         nbytes_q <= head_i.nbytes;
         src_q    <= head_i.src;
         data_q   <= '0;
      end else if ((state_q == ENG_DATA) && half_end) begin
         if (!sclk_q) begin
            byte_sr_q <= {byte_sr_q[6:0], miso_i};
         end else if (bit_cnt_q[2:0] == 3'b111) begin
            data_q[{byte_idx, 3'b000} +: 8] <= byte_sr_q;
         end
      end
   end

   assign sclk_o      = sclk_q;
   assign ss_o        = ss_q;
   assign mosi_o      = tx_q[TX_W-1];
   assign rsp_valid_o = rsp_valid_q;
   assign rsp_o.data  = data_q;
   assign rsp_o.src   = src_q;

endmodule

//--- rtl/spi_flash_rd_top.sv
`timescale 1ns/1ps

module spi_flash_rd_top (
   input  logic                     clk_i,
   input  logic                     arst_i,
   input  logic                     csr_soft_rst_i,
   input  logic                     csr_valid_i,
   input  spi_flash_pkg::spi_req_t  csr_req_i,
   output logic                     csr_busy_o,
   output logic                     csr_rsp_valid_o,
   output spi_flash_pkg::spi_word_t csr_rdata_o,
   input  logic                     cache_valid_i,
   input  spi_flash_pkg::spi_addr_t cache_addr_i,
   input  logic [3:0]               cache_wstrb_i,
   output logic                     cache_ready_o,
   output spi_flash_pkg::spi_word_t cache_rdata_o,
   output logic                     sclk_o,
   output logic                     ss_o,
   output logic                     mosi_o,
   input  logic                     miso_i
);
   import spi_flash_pkg::*;

   spi_req_t push_req;
   spi_req_t head;
   spi_rsp_t rsp;
   logic     push;
   logic     pop;
   logic     empty;
   logic     full;
   logic     rsp_valid;
   logic     rst_int;

   // Hard or soft reset for queue and engine
   assign rst_int = arst_i | csr_soft_rst_i;

   spi_req_arbiter u_arb (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .flush_i        (csr_soft_rst_i),
      .csr_valid_i    (csr_valid_i),
      .csr_req_i      (csr_req_i),
      .csr_busy_o     (csr_busy_o),
      .csr_rsp_valid_o(csr_rsp_valid_o),
      .csr_rdata_o    (csr_rdata_o),
      .cache_valid_i  (cache_valid_i),
      .cache_addr_i   (cache_addr_i),
      .cache_wstrb_i  (cache_wstrb_i),
      .cache_ready_o  (cache_ready_o),
      .cache_rdata_o  (cache_rdata_o),
      .push_o         (push),
      .push_req_o     (push_req),
      .full_i         (full),
      .rsp_valid_i    (rsp_valid),
      .rsp_i          (rsp)
   );

   spi_req_fifo u_fifo (
      .clk_i     (clk_i),
      .arst_i    (rst_int),
      .push_i    (push),
      .push_req_i(push_req),
      .pop_i     (pop),
      .head_o    (head),
      .empty_o   (empty),
      .full_o    (full)
   );

   spi_frame_engine u_eng (
      .clk_i      (clk_i),
      .arst_i     (rst_int),
      .empty_i    (empty),
      .head_i     (head),
      .pop_o      (pop),
      .rsp_valid_o(rsp_valid),
      .rsp_o      (rsp),
      .sclk_o     (sclk_o),
      .ss_o       (ss_o),
      .mosi_o     (mosi_o),
      .miso_i     (miso_i)
   );

endmodule

//--- dv/spi_flash_model.sv
`timescale 1ns/1ps
`include "spi_flash_config.svh"

module spi_flash_model (
   input  logic sclk_i,
   input  logic ss_i,
   input  logic mosi_i,
   output logic miso_o
);
   localparam int ADDR_W   = `SPI_ADDR_W;
   localparam int CMD_BITS = 8 + ADDR_W;

   logic [CMD_BITS-1:0] cmd_sr   = '0;
   logic [ADDR_W-1:0]   addr_q   = '0;
   logic [ADDR_W-1:0]   byte_addr;
   logic [7:0]          cur_byte;
   logic [2:0]          bit_sel;
   logic                miso_q   = 1'b0;
   int                  bit_cnt  = 0;
   int                  data_bit;

   // Opcode and address come in MSB first on rising SCLK
   always @(posedge sclk_i or posedge ss_i) begin
      if (ss_i) begin
         bit_cnt = 0;
      end else begin
         if (bit_cnt < CMD_BITS) begin
            cmd_sr = {cmd_sr[CMD_BITS-2:0], mosi_i};
         end
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == CMD_BITS) begin
            addr_q = cmd_sr[ADDR_W-1:0];
         end
      end
   end

   // Data goes out on falling SCLK, address steps per byte
   always @(negedge sclk_i) begin
      if (!ss_i && bit_cnt >= CMD_BITS) begin
         data_bit  = bit_cnt - CMD_BITS;
         byte_addr = addr_q + ADDR_W'(data_bit / 8);
         cur_byte  = byte_addr[7:0] ^ 8'h5A;
         bit_sel   = 3'(7 - (data_bit % 8));
         miso_q    = cur_byte[bit_sel];
      end
   end

   assign miso_o = miso_q;

endmodule

//--- dv/spi_flash_rd_properties.sv
`timescale 1ns/1ps

module spi_flash_rd_properties (
   input logic clk_i,
   input logic arst_i,
   input logic ss_i,
   input logic sclk_i,
   input logic cache_valid_i,
   input logic cache_ready_i,
   input logic csr_rsp_valid_i
);

   sclk_idle_deselected: assert property (@(posedge clk_i) disable iff (arst_i)
      ss_i |-> !sclk_i)
      else $error("sclk_o high while ss_o is high");

   ss_high_in_reset: assert property (@(posedge clk_i) arst_i |=> ss_i)
      else $error("ss_o low after reset");

   // Ready only answers a pending cache request
   ready_needs_valid: assert property (@(posedge clk_i) disable iff (arst_i)
      cache_ready_i |-> cache_valid_i)
      else $error("cache_ready_o without cache_valid_i");

   csr_rsp_one_cycle: assert property (@(posedge clk_i) disable iff (arst_i)
      csr_rsp_valid_i |=> !csr_rsp_valid_i)
      else $error("csr_rsp_valid_o longer than one cycle");

   cache_ready_one_cycle: assert property (@(posedge clk_i) disable iff (arst_i)
      cache_ready_i |=> !cache_ready_i)
      else $error("cache_ready_o longer than one cycle");

endmodule

bind spi_flash_rd_top spi_flash_rd_properties props_i (
   .clk_i          (clk_i),
   .arst_i         (arst_i),
   .ss_i           (ss_o),
   .sclk_i         (sclk_o),
   .cache_valid_i  (cache_valid_i),
   .cache_ready_i  (cache_ready_o),
   .csr_rsp_valid_i(csr_rsp_valid_o)
);

//--- dv/tb_spi_flash_rd.sv
`timescale 1ns/1ps
`include "spi_flash_config.svh"

module tb_spi_flash_rd;
   import spi_flash_pkg::*;

   localparam int FRAME_MAX  = (8 + `SPI_ADDR_W + 32) * 2 * `SPI_HALF_SCLK + 2;
   localparam int N_REQ      = 28;
   localparam int TIMEOUT_NS = (16 + 2 * N_REQ * FRAME_MAX) * 20;

   logic      clk_i;
   logic      arst_i;
   logic      csr_soft_rst_i;
   logic      csr_valid_i;
   spi_req_t  csr_req_i;
   logic      csr_busy_o;
   logic      csr_rsp_valid_o;
   spi_word_t csr_rdata_o;
   logic      cache_valid_i;
   spi_addr_t cache_addr_i;
   logic [3:0] cache_wstrb_i;
   logic      cache_ready_o;
   spi_word_t cache_rdata_o;
   logic      sclk_o;
   logic      ss_o;
   logic      mosi_o;
   logic      miso_i;

   spi_word_t csr_exp_q[$];
   spi_word_t cache_exp_q[$];
   int        cache_ack_cnt = 0;

   spi_flash_rd_top dut_i (.*);

   spi_flash_model flash_i (
      .sclk_i(sclk_o),
      .ss_i  (ss_o),
      .mosi_i(mosi_o),
      .miso_o(miso_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   // Flash byte at a is a[7:0] ^ 5A and the first byte lands in bits 7:0
   function automatic spi_word_t expected_word(input spi_addr_t addr, input spi_nbytes_t nb);
      spi_word_t w;
      spi_addr_t a;
      w = '0;
      for (int k = 0; k <= int'(nb); k++) begin
         a = addr + spi_addr_t'(k);
         w = w | (spi_word_t'(a[7:0] ^ 8'h5A) << (8 * k));
      end
      return w;
   endfunction

   task automatic issue_csr(input spi_addr_t addr, input spi_nbytes_t nb);
      logic accepted;
      accepted = 1'b0;
      @(negedge clk_i);
      csr_req_i.op     = spi_op_t'($urandom);
      csr_req_i.addr   = addr;
      csr_req_i.nbytes = nb;
      csr_req_i.src    = SRC_CACHE;
      csr_valid_i      = 1'b1;
      while (!accepted) begin
         @(posedge clk_i);
         if (!csr_busy_o) begin
            accepted = 1'b1;
            csr_exp_q.push_back(expected_word(addr, nb));
         end
         @(negedge clk_i);
      end
      csr_valid_i = 1'b0;
   endtask

   task automatic cache_access(input spi_addr_t addr, input logic [3:0] strb);
      int acks_before;
      @(negedge clk_i);
      acks_before   = cache_ack_cnt;
      cache_addr_i  = addr;
      cache_wstrb_i = strb;
      cache_valid_i = 1'b1;
      if (strb == 4'h0) begin
         cache_exp_q.push_back(expected_word(addr, 2'd3));
      end
      @(posedge clk_i);
      while (!cache_ready_o) begin
         @(posedge clk_i);
      end
      @(negedge clk_i);
      cache_valid_i = 1'b0;
      cache_wstrb_i = 4'h0;
      repeat (3) begin
         @(posedge clk_i);
         // Writes must never open a frame
         assert (strb == 4'h0 || ss_o === 1'b1)
            else abort_run("cache write started an SPI frame");
      end
      @(negedge clk_i);
      assert (cache_ack_cnt == acks_before + 1)
         else abort_run("cache request did not get exactly one cache_ready_o pulse");
   endtask

   task automatic wait_idle();
      while (csr_exp_q.size() != 0 || cache_exp_q.size() != 0) begin
         @(posedge clk_i);
      end
   endtask

   always @(posedge clk_i) begin
      spi_word_t exp_word;
      if (!arst_i) begin
         if (csr_rsp_valid_o) begin
            assert (csr_exp_q.size() != 0)
               else abort_run("register response with no command outstanding");
            exp_word = csr_exp_q.pop_front();
            assert (csr_rdata_o === exp_word)
               else abort_run($sformatf("error: time %0t, csr_rdata_o expected %h, got %h",
                                        $time, exp_word, csr_rdata_o));
         end
         if (cache_ready_o) begin
            cache_ack_cnt++;
            if (cache_wstrb_i == 4'h0) begin
               assert (cache_exp_q.size() != 0)
                  else abort_run("cache read response with no read outstanding");
               exp_word = cache_exp_q.pop_front();
               assert (cache_rdata_o === exp_word)
                  else abort_run($sformatf("error: time %0t, cache_rdata_o expected %h, got %h",
                                           $time, exp_word, cache_rdata_o));
            end
         end
      end
   end

   initial begin
      #(TIMEOUT_NS);
      abort_run("watchdog expired before the tests finished");
   end

   initial begin
      int i;
      void'($urandom(15369));
      arst_i         = 1'b1;
      csr_soft_rst_i = 1'b0;
      csr_valid_i    = 1'b0;
      csr_req_i      = '0;
      cache_valid_i  = 1'b0;
      cache_addr_i   = '0;
      cache_wstrb_i  = 4'h0;
      repeat (16) @(negedge clk_i);
      arst_i = 1'b0;
      assert (ss_o === 1'b1 && sclk_o === 1'b0 && mosi_o === 1'b0 && csr_busy_o === 1'b0 &&
              csr_rsp_valid_o === 1'b0 && cache_ready_o === 1'b0)
         else abort_run("outputs not at their reset values after reset");

      // Register reads of every length and one that wraps past the top address
      for (i = 0; i < 12; i++) begin
         issue_csr((i == 11) ? spi_addr_t'(24'hFFFFFE) : spi_addr_t'($urandom),
                   spi_nbytes_t'(i % 4));
      end
      wait_idle();

      for (i = 0; i < 4; i++) begin
         cache_access(spi_addr_t'($urandom), 4'h0);
      end
      cache_access(spi_addr_t'($urandom), 4'hF);
      cache_access(spi_addr_t'($urandom), 4'h1);

      // Cache read lands in the same cycle as the first register strobe
      fork
         begin
            for (int j = 0; j < 6; j++) begin
               issue_csr(spi_addr_t'($urandom), spi_nbytes_t'($urandom_range(3, 0)));
            end
         end
         cache_access(spi_addr_t'($urandom), 4'h0);
      join
      wait_idle();

      issue_csr(spi_addr_t'($urandom), 2'd3);
      while (ss_o) begin
         @(posedge clk_i);
      end
      repeat (40) @(posedge clk_i);
      @(negedge clk_i);
      csr_soft_rst_i = 1'b1;
      csr_exp_q.delete();
      @(negedge clk_i);
      csr_soft_rst_i = 1'b0;
      assert (ss_o === 1'b1)
         else abort_run("ss_o did not return high after soft reset");
      repeat (FRAME_MAX) @(posedge clk_i);
      issue_csr(spi_addr_t'($urandom), 2'd2);
      wait_idle();

      $display("TEST PASS");
      $finish;
   end

endmodule

//--- spi_flash_rd.f
+incdir+rtl
rtl/spi_flash_pkg.sv
rtl/spi_req_arbiter.sv
rtl/spi_req_fifo.sv
rtl/spi_frame_engine.sv
rtl/spi_flash_rd_top.sv
dv/spi_flash_model.sv
dv/spi_flash_rd_properties.sv
dv/tb_spi_flash_rd.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_spi_flash_rd
FILELIST   ?= spi_flash_rd.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# A simulator error exit is logged as a failure too
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TEST FAIL" >> $(LOG)
	cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
